/* verilog/egress_pkg.sv */
////////////////////////////////////////////////////////////
// Sizes, word types and packet states for the egress stage.
// Every egress module takes these by wildcard import.
////////////////////////////////////////////////////////////

package egress_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    // Egress ports and the width of a port number
    localparam int num_ports = 4;
    localparam int port_w    = 2;

    // Bytes carried by one stream word
    localparam int data_bytes = 8;

    // Words per port buffer, also the upstream credit per port
    localparam int buf_depth = 16;
    localparam int buf_ptr_w = $clog2(buf_depth);

    // Delivered-packet counter width
    localparam int cnt_w = 16;

    ////////////////////////////////////////////////////////////
    // Stream types

    // One stream word, keep is contiguous from byte 0
    typedef struct packed {
        logic [data_bytes*8-1:0] data;
        logic [data_bytes-1:0]   keep;
        logic                    last;
    } egr_word_t;

    // Input beat with its egress port
    typedef struct packed {
        logic              valid;
        logic [port_w-1:0] port;
        egr_word_t         word;
    } egr_in_t;

    // Credits handed back to one port in one cycle, 0 to 2
    typedef logic [1:0] credit_cnt_t;

    ////////////////////////////////////////////////////////////
    // Control state

    // Where the input stream is within a packet
    typedef enum logic [1:0] {
        pkt_start,
        pkt_forward,
        pkt_discard
    } pkt_state_e;

endpackage

/* verilog/egress_ctrl.sv */
////////////////////////////////////////////////////////////
// Steers input packets to port buffers or drops them whole,
// and returns upstream credits for popped or dropped words.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module egress_ctrl
    import egress_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  egr_in_t                     egr_in,
    input  logic [num_ports-1:0]        port_enable,
    input  logic [num_ports-1:0]        pop,
    output logic [num_ports-1:0]        wr_en,
    output egr_word_t                   wr_word,
    output credit_cnt_t [num_ports-1:0] credit_return
);

    pkt_state_e           state;
    pkt_state_e           state_nxt;
    logic [port_w-1:0]    port_q;
    logic [port_w-1:0]    sel_port;
    logic                 fwd;
    logic [num_ports-1:0] discard;

    ////////////////////////////////////////////////////////////
    // Packet FSM

    always_comb begin
        state_nxt = state;

        // First word decides for the whole packet
        if (state == pkt_start) begin
            sel_port = egr_in.port;
            fwd      = port_enable[egr_in.port];
        end else begin
            sel_port = port_q;
            fwd      = (state == pkt_forward);
        end

        if (egr_in.valid) begin
            if (egr_in.word.last) begin
                state_nxt = pkt_start;
            end else if (state == pkt_start) begin
                state_nxt = fwd ? pkt_forward : pkt_discard;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= pkt_start;
            port_q <= '0;
        end else begin
            state <= state_nxt;
            if (egr_in.valid && state == pkt_start) begin
                port_q <= egr_in.port;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Write stage toward the buffers

    // One-hot write strobe, dropped words only mark a discard
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en   <= '0;
            discard <= '0;
        end else begin
            wr_en   <= '0;
            discard <= '0;
            if (egr_in.valid) begin
                if (fwd) begin
                    wr_en[sel_port] <= 1'b1;
                end else begin
                    discard[sel_port] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (egr_in.valid) begin
            wr_word <= egr_in.word;
        end
    end

    ////////////////////////////////////////////////////////////
    // Credit return

    // A port can free a slot by pop and by discard in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_return <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                credit_return[p] <= {1'b0, pop[p]} + {1'b0, discard[p]};
            end
        end
    end

endmodule

/* verilog/egress_port_buffer.sv */
////////////////////////////////////////////////////////////
// Word FIFO for one egress port, head word drives the port
// stream and every transfer pulses pop for credit return.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module egress_port_buffer
    import egress_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  egr_word_t wr_word,
    output egr_word_t out_word,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      pop
);

    // Storage and pointers
    egr_word_t            mem [buf_depth];
    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;

    // Occupancy needs one bit more than the pointers
    logic [buf_ptr_w:0]   count;
    logic                 rd_en;

    ////////////////////////////////////////////////////////////
    // Output stream

    // Head word stays put until the sink takes it
    assign out_valid = (count != '0);
    assign out_word  = mem[rd_ptr];
    assign rd_en     = out_valid & out_ready;

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy

    // Depth is a power of two, so pointers wrap by themselves
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Upstream credits keep writes from ever hitting a full FIFO
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Pop pulse

    // One cycle after each transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            pop <= 1'b0;
        end else begin
            pop <= rd_en;
        end
    end

endmodule

/* verilog/egress_pkt_counters.sv */
////////////////////////////////////////////////////////////
// Per-port delivered-packet counters, saturating, each with
// its own clear.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module egress_pkt_counters
    import egress_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [num_ports-1:0]            out_valid,
    input  logic [num_ports-1:0]            out_ready,
    input  logic [num_ports-1:0]            out_last,
    input  logic [num_ports-1:0]            cnt_clear,
    output logic [num_ports-1:0][cnt_w-1:0] pkt_count
);

    // Last-word transfers seen on the previous edge
    logic [num_ports-1:0] last_xfer;

    ////////////////////////////////////////////////////////////
    // End-of-packet detect

    always_ff @(posedge clk) begin
        if (rst) begin
            last_xfer <= '0;
        end else begin
            last_xfer <= out_valid & out_ready & out_last;
        end
    end

    ////////////////////////////////////////////////////////////
    // Counters

    // Clear has priority over a pending increment
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (cnt_clear[p]) begin
                    pkt_count[p] <= '0;
                end else if (last_xfer[p] && pkt_count[p] != '1) begin
                    pkt_count[p] <= pkt_count[p] + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/router_egress.sv */
////////////////////////////////////////////////////////////
// Egress stage top level: control, four port buffers and
// the packet counters.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module router_egress
    import egress_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  egr_in_t                         egr_in,
    input  logic [num_ports-1:0]            port_enable,
    input  logic [num_ports-1:0]            cnt_clear,
    input  logic [num_ports-1:0]            out_ready,
    output credit_cnt_t [num_ports-1:0]     credit_return,
    output egr_word_t [num_ports-1:0]       out_word,
    output logic [num_ports-1:0]            out_valid,
    output logic [num_ports-1:0][cnt_w-1:0] pkt_count
);

    // Control to buffers
    logic [num_ports-1:0] wr_en;
    egr_word_t            wr_word;

    // Buffers back to control and counters
    logic [num_ports-1:0] pop;
    logic [num_ports-1:0] out_last;

    ////////////////////////////////////////////////////////////
    // Control

    egress_ctrl i_egress_ctrl (
        .clk           (clk),
        .rst           (rst),
        .egr_in        (egr_in),
        .port_enable   (port_enable),
        .pop           (pop),
        .wr_en         (wr_en),
        .wr_word       (wr_word),
        .credit_return (credit_return)
    );

    ////////////////////////////////////////////////////////////
    // Port buffers

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        egress_port_buffer i_egress_port_buffer (
            .clk       (clk),
            .rst       (rst),
            .wr_en     (wr_en[p]),
            .wr_word   (wr_word),
            .out_word  (out_word[p]),
            .out_valid (out_valid[p]),
            .out_ready (out_ready[p]),
            .pop       (pop[p])
        );

        assign out_last[p] = out_word[p].last;
    end

    ////////////////////////////////////////////////////////////
    // Packet counters

    egress_pkt_counters i_egress_pkt_counters (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .cnt_clear (cnt_clear),
        .pkt_count (pkt_count)
    );

endmodule

/* test/router_egress_checker.sv */
////////////////////////////////////////////////////////////
// Scoreboard for the egress testbench. Compares the port
// streams, upstream credits and packet counts with expectations.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module router_egress_checker
    import egress_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [num_ports-1:0]            out_valid,
    input  logic [num_ports-1:0]            out_ready,
    input  egr_word_t [num_ports-1:0]       out_word,
    input  credit_cnt_t [num_ports-1:0]     credit_return,
    input  logic [num_ports-1:0][cnt_w-1:0] pkt_count,
    input  logic [num_ports-1:0]            cnt_clear,
    input  logic [num_ports-1:0][7:0]       credits,
    input  logic                            exp_push,
    input  logic [port_w-1:0]               exp_port,
    input  egr_word_t                       exp_word,
    input  logic                            check_req,
    output int                              data_errs,
    output int                              credit_errs,
    output int                              count_errs
);

    egr_word_t            exp_q [num_ports][$];
    egr_word_t            exp;
    int                   delivered [num_ports];
    logic [num_ports-1:0] last_seen = '0;
    logic                 rst_d = 1'b0;
    int                   n_data = 0;
    int                   n_credit = 0;
    int                   n_count = 0;

    assign data_errs   = n_data;
    assign credit_errs = n_credit;
    assign count_errs  = n_count;

    always @(posedge clk) begin
        // Outputs stay quiet through reset and one cycle past it
        if (rst_d && (out_valid != '0 || credit_return != '0)) begin
            $display("[ERROR] %0t: activity in reset, out_valid %b credit_return %h",
                     $time, out_valid, credit_return);
            n_data++;
        end
        rst_d = rst;

        if (rst) begin
            for (int p = 0; p < num_ports; p++) begin
                exp_q[p].delete();
                delivered[p] = 0;
            end
            last_seen = '0;
        end else begin
            if (exp_push) begin
                exp_q[exp_port].push_back(exp_word);
            end
            for (int p = 0; p < num_ports; p++) begin
                if (credits[p] > 8'(buf_depth)) begin
                    $display("[ERROR] %0t: port %0d upstream credit %0d above depth",
                             $time, p, credits[p]);
                    n_credit++;
                end

                ////////////////////////////////////////////////////////////
                // Idle checks on request
                if (check_req) begin
                    if (exp_q[p].size() != 0) begin
                        $display("[ERROR] %0t: port %0d still expects %0d words",
                                 $time, p, exp_q[p].size());
                        n_data++;
                    end
                    if (credits[p] != 8'(buf_depth)) begin
                        $display("[ERROR] %0t: port %0d credit %0d not restored",
                                 $time, p, credits[p]);
                        n_credit++;
                    end
                    if (pkt_count[p] != cnt_w'(delivered[p])) begin
                        $display("[ERROR] %0t: port %0d pkt_count %0d, expected %0d",
                                 $time, p, pkt_count[p], delivered[p]);
                        n_count++;
                    end
                end

                // Count model lags the transfer by one cycle, clear beats increment
                if (cnt_clear[p]) begin
                    delivered[p] = 0;
                end else if (last_seen[p]) begin
                    delivered[p]++;
                end
                last_seen[p] = out_valid[p] & out_ready[p] & out_word[p].last;

                ////////////////////////////////////////////////////////////
                // Stream compare
                if (out_valid[p] && out_ready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("[ERROR] %0t: port %0d sent %h with nothing expected",
                                 $time, p, out_word[p]);
                        n_data++;
                    end else begin
                        exp = exp_q[p].pop_front();
                        if (out_word[p] != exp) begin
                            $display("[ERROR] %0t: port %0d word %h, expected %h",
                                     $time, p, out_word[p], exp);
                            n_data++;
                        end
                    end
                end
            end
        end
    end

endmodule

/* test/router_egress_tb.sv */
////////////////////////////////////////////////////////////
// Random packet testbench for the egress stage, simulation
// top with credit-aware upstream and the checker alongside.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module router_egress_tb
    import egress_pkg::*;
();

    localparam int          num_pkts   = 200;
    localparam int          rst_cycles = 16;
    localparam int          wait_limit = 2000;
    localparam int          max_words  = 8;
    localparam logic [15:0] lfsr_seed  = 16'd8583;

    logic                            core_clk_ifc = 1'b0;
    logic                            rst;
    egr_in_t                         egr_in;
    logic [num_ports-1:0]            port_enable;
    logic [num_ports-1:0]            cnt_clear;
    logic [num_ports-1:0]            out_ready;
    credit_cnt_t [num_ports-1:0]     credit_return;
    egr_word_t [num_ports-1:0]       out_word;
    logic [num_ports-1:0]            out_valid;
    logic [num_ports-1:0][cnt_w-1:0] pkt_count;

    // Upstream credit view and expected-word feed to the checker
    logic [num_ports-1:0][7:0]       credits;
    logic                            exp_push;
    logic [port_w-1:0]               exp_port;
    egr_word_t                       exp_word;
    logic                            check_req;
    int                              data_errs;
    int                              credit_errs;
    int                              count_errs;
    logic [15:0]                     lfsr_state;
    logic                            draining;
    logic                            timed_out;

    always #50 core_clk_ifc = ~core_clk_ifc;

    router_egress i_router_egress (
        .clk (core_clk_ifc),
        .*
    );

    router_egress_checker i_router_egress_checker (
        .clk (core_clk_ifc),
        .*
    );

    // One word spends a credit and returns add it back
    always @(posedge core_clk_ifc) begin
        for (int p = 0; p < num_ports; p++) begin
            if (rst) begin
                credits[p] <= 8'(buf_depth);
            end else begin
                credits[p] <= credits[p] + 8'(credit_return[p])
                              - 8'(egr_in.valid && egr_in.port == port_w'(p));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Random bits and reference words

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Byte b of the payload lands in data[8*b +: 8] of its word
    function automatic void build_words(input int len, input logic [7:0] payload [64],
                                        output egr_word_t words [max_words],
                                        output int n_words);
        n_words = (len + data_bytes - 1) / data_bytes;
        for (int w = 0; w < max_words; w++) begin
            words[w] = '0;
            for (int b = 0; b < data_bytes; b++) begin
                if (w * data_bytes + b < len) begin
                    words[w].data[b*8 +: 8] = payload[w * data_bytes + b];
                    words[w].keep[b]        = 1'b1;
                end
            end
            words[w].last = (w == n_words - 1);
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus

    task automatic next_cycle();
        int r;

        @(posedge core_clk_ifc);
        #1;
        egr_in    = '0;
        exp_push  = 1'b0;
        check_req = 1'b0;
        cnt_clear = '0;
        // Sink takes a word about one cycle in four, so buffers fill and credits run out
        for (int p = 0; p < num_ports; p++) begin
            take_bits(2, r);
            out_ready[p] = draining || (r == 0);
        end
    endtask

    task automatic send_packet();
        logic [port_w-1:0] port;
        logic [7:0]        payload [64];
        egr_word_t         words [max_words];
        logic              en;
        int                len;
        int                val;
        int                n_words;
        int                wait_cnt;

        take_bits(port_w, val);
        port = port_w'(val);
        take_bits(6, len);
        len = len + 1;
        for (int i = 0; i < 64; i++) begin
            payload[i] = '0;
            if (i < len) begin
                take_bits(8, val);
                payload[i] = val[7:0];
            end
        end
        build_words(len, payload, words, n_words);
        take_bits(2, val);
        repeat (val) begin
            next_cycle();
        end
        for (int w = 0; w < n_words; w++) begin
            next_cycle();
            wait_cnt = 0;
            while (credits[port] == '0 && !timed_out) begin
                if (wait_cnt == wait_limit) begin
                    $display("Timeout: no upstream credit for port %0d", port);
                    timed_out = 1'b1;
                end else begin
                    next_cycle();
                    wait_cnt++;
                end
            end
            if (timed_out) begin
                return;
            end
            // Now and then a port is switched just before a first word
            if (w == 0) begin
                take_bits(3, val);
                if (val == 0) begin
                    port_enable[port] = ~port_enable[port];
                end
                en = port_enable[port];
            end
            egr_in.valid = 1'b1;
            egr_in.port  = port;
            egr_in.word  = words[w];
            exp_push     = en;
            exp_port     = port;
            exp_word     = words[w];
        end
    endtask

    initial begin
        int   wait_cnt;
        logic idle;

        lfsr_state  = lfsr_seed;
        rst         = 1'b1;
        egr_in      = '0;
        port_enable = '1;
        cnt_clear   = '0;
        out_ready   = '0;
        exp_push    = 1'b0;
        exp_port    = '0;
        exp_word    = '0;
        check_req   = 1'b0;
        draining    = 1'b0;
        timed_out   = 1'b0;
        repeat (rst_cycles) begin
            @(posedge core_clk_ifc);
        end
        #1;
        rst = 1'b0;

        for (int i = 0; i < num_pkts && !timed_out; i++) begin
            send_packet();
        end

        // Let every buffer empty and every credit come home
        draining = 1'b1;
        wait_cnt = 0;
        idle     = 1'b0;
        while (!idle && !timed_out) begin
            next_cycle();
            idle = (out_valid == '0);
            for (int p = 0; p < num_ports; p++) begin
                if (credits[p] != 8'(buf_depth)) begin
                    idle = 1'b0;
                end
            end
            if (!idle && wait_cnt == wait_limit) begin
                $display("Timeout: buffers or credits did not settle after traffic");
                timed_out = 1'b1;
            end
            wait_cnt++;
        end

        if (!timed_out) begin
            repeat (3) begin
                next_cycle();
            end
            check_req = 1'b1;
            next_cycle();
            cnt_clear[2] = 1'b1;
            repeat (3) begin
                next_cycle();
            end
            check_req = 1'b1;
            next_cycle();
            next_cycle();
        end

        $display("Errors: %0d data, %0d credit, %0d count", data_errs, credit_errs, count_errs);
        if (timed_out || data_errs + credit_errs + count_errs != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/egress_pkg.sv
verilog/egress_ctrl.sv
verilog/egress_port_buffer.sv
verilog/egress_pkt_counters.sv
verilog/router_egress.sv
test/router_egress_checker.sv
test/router_egress_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the egress testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module router_egress_tb -f compile.f \
    && ./obj_dir/Vrouter_egress_tb | tee /dev/stderr | grep -F "TESTBENCH PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
